// ==== dma_block_pkg.sv ====
// widths, block geometry and FIFO depth shared by the
// block DMA path

`default_nettype none

package dma_block_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int ADDR_W = 64;
  localparam int LEN_W  = 8;
  localparam int DATA_W = 512;

  // --------------------------------------------------
  // block geometry
  // --------------------------------------------------
  // one 4 KiB block is 64 lines of 512 bits
  localparam int BLOCK_BEATS = 64;
  localparam int BEAT_CNT_W  = 6;

  // ready and finished block counters
  localparam int BLOCK_CNT_W = 13;

  // --------------------------------------------------
  // address FIFO
  // --------------------------------------------------
  localparam int ADDR_FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W      = $clog2(ADDR_FIFO_DEPTH);

endpackage

`default_nettype wire

// ==== block_addr_fifo.sv ====
// show-ahead FIFO holding block address and burst length

`timescale 1ns/10ps
`default_nettype none

module block_addr_fifo
  import dma_block_pkg::*;
(
  input  wire               aclk,
  input  wire               aresetn,
  input  wire               push,
  input  wire  [ADDR_W-1:0] push_addr,
  input  wire  [LEN_W-1:0]  push_len,
  input  wire               pop,
  output logic [ADDR_W-1:0] head_addr,
  output logic [LEN_W-1:0]  head_len,
  output logic              head_valid,
  output logic              full
);

  logic [ADDR_W-1:0]   addr_mem [ADDR_FIFO_DEPTH];
  logic [LEN_W-1:0]    len_mem  [ADDR_FIFO_DEPTH];
  // extra msb tells full from empty
  logic [FIFO_PTR_W:0] wr_ptr;
  logic [FIFO_PTR_W:0] rd_ptr;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      addr_mem[wr_ptr[FIFO_PTR_W-1:0]] <= push_addr;
      len_mem[wr_ptr[FIFO_PTR_W-1:0]]  <= push_len;
    end
  end

  assign head_addr  = addr_mem[rd_ptr[FIFO_PTR_W-1:0]];
  assign head_len   = len_mem[rd_ptr[FIFO_PTR_W-1:0]];
  assign head_valid = (wr_ptr != rd_ptr);
  assign full       = (wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]) &&
                      (wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]);

  // the callers must respect the FIFO limits
  assert property (@(posedge aclk) disable iff (!aresetn) push |-> !full)
    else $error("block_addr_fifo: push while full");

  assert property (@(posedge aclk) disable iff (!aresetn) pop |-> head_valid)
    else $error("block_addr_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== ingest_tracker.sv ====
// input side: records host write addresses, counts written blocks
// and issues one memory A read per ready block

`timescale 1ns/10ps
`default_nettype none

module ingest_tracker
  import dma_block_pkg::*;
(
  input  wire               aclk,
  input  wire               aresetn,
  // host write, observed only
  input  wire  [ADDR_W-1:0] host_awaddr,
  input  wire  [LEN_W-1:0]  host_awlen,
  input  wire               host_awvalid,
  input  wire               host_awready,
  input  wire               host_bvalid,
  input  wire               host_bready,
  // memory A read address
  input  wire               ddra_arready,
  output logic              ddra_arvalid,
  output logic [ADDR_W-1:0] ddra_araddr,
  output logic [LEN_W-1:0]  ddra_arlen,
  // accepted read, towards the output side
  output logic              issue_fire,
  output logic [ADDR_W-1:0] issue_addr,
  output logic [LEN_W-1:0]  issue_len
);

  logic                   aw_fire;
  logic                   b_fire;
  logic                   head_valid;
  logic [ADDR_W-1:0]      head_addr;
  logic [LEN_W-1:0]       head_len;
  logic [BLOCK_CNT_W-1:0] ready_cnt;

  assign aw_fire = host_awvalid & host_awready;
  assign b_fire  = host_bvalid & host_bready;

  block_addr_fifo u_rd_addr_fifo (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push       (aw_fire),
    .push_addr  (host_awaddr),
    .push_len   (host_awlen),
    .pop        (issue_fire),
    .head_addr  (head_addr),
    .head_len   (head_len),
    .head_valid (head_valid),
    .full       ()
  );

  // --------------------------------------------------
  // ready block count
  // --------------------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ready_cnt <= '0;
    end else if (b_fire && !issue_fire) begin
      ready_cnt <= ready_cnt + 1'b1;
    end else if (issue_fire && !b_fire) begin
      ready_cnt <= ready_cnt - 1'b1;
    end
  end

  assign ddra_arvalid = head_valid && (ready_cnt != '0);
  assign ddra_araddr  = head_addr;
  assign ddra_arlen   = head_len;

  assign issue_fire = ddra_arvalid & ddra_arready;
  assign issue_addr = head_addr;
  assign issue_len  = head_len;

  // every ready block still has its address queued
  assert property (@(posedge aclk) disable iff (!aresetn)
    ready_cnt != '0 |-> head_valid)
    else $error("ingest_tracker: ready count without a queued address");

  assert property (@(posedge aclk) disable iff (!aresetn)
    ddra_arvalid && !ddra_arready |=>
      ddra_arvalid && $stable(ddra_araddr) && $stable(ddra_arlen))
    else $error("ingest_tracker: ddra_arvalid dropped before transfer");

endmodule

`default_nettype wire

// ==== writeback_ctrl.sv ====
// output side: memory C write address and data, burst end marking,
// finished block count and the host read gate

`timescale 1ns/10ps
`default_nettype none

module writeback_ctrl
  import dma_block_pkg::*;
(
  input  wire               aclk,
  input  wire               aresetn,
  // accepted memory A reads
  input  wire               issue_fire,
  input  wire  [ADDR_W-1:0] issue_addr,
  input  wire  [LEN_W-1:0]  issue_len,
  // memory C write address
  input  wire               ddrc_awready,
  output logic              ddrc_awvalid,
  output logic [ADDR_W-1:0] ddrc_awaddr,
  output logic [LEN_W-1:0]  ddrc_awlen,
  // accelerator results to memory C write data
  input  wire  [DATA_W-1:0] fifo_out_bits,
  input  wire               fifo_out_vld,
  input  wire               ddrc_wready,
  output logic [DATA_W-1:0] ddrc_wdata,
  output logic              ddrc_wvalid,
  output logic              ddrc_wlast,
  output logic              ddrc_bready,
  output logic              fifo_out_rdy,
  input  wire               ddrc_bvalid,
  // host read gate
  input  wire               host_arvalid,
  input  wire               ddrc_arready,
  output logic              host_arready,
  output logic              ddrc_arvalid
);

  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   rd_take;
  logic                   output_avail;
  logic [BEAT_CNT_W-1:0]  beat_cnt;
  logic [BLOCK_CNT_W-1:0] done_cnt;

  // --------------------------------------------------
  // memory C write address
  // --------------------------------------------------
  block_addr_fifo u_wr_addr_fifo (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push       (issue_fire),
    .push_addr  (issue_addr),
    .push_len   (issue_len),
    .pop        (aw_fire),
    .head_addr  (ddrc_awaddr),
    .head_len   (ddrc_awlen),
    .head_valid (ddrc_awvalid),
    .full       ()
  );

  assign aw_fire = ddrc_awvalid & ddrc_awready;

  // --------------------------------------------------
  // write data and burst end
  // --------------------------------------------------
  assign ddrc_wdata   = fifo_out_bits;
  assign ddrc_wvalid  = fifo_out_vld;
  assign fifo_out_rdy = ddrc_wready;
  assign w_fire       = fifo_out_vld & ddrc_wready;

  // counter wraps back to zero after the last beat of a block
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (w_fire) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign ddrc_wlast = (beat_cnt == BEAT_CNT_W'(BLOCK_BEATS - 1));

  // --------------------------------------------------
  // finished blocks and host read gate
  // --------------------------------------------------
  assign ddrc_bready  = 1'b1;
  assign b_fire       = ddrc_bvalid;
  assign output_avail = (done_cnt != '0);
  assign rd_take      = host_arvalid & ddrc_arready & output_avail;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      done_cnt <= '0;
    end else if (b_fire && !rd_take) begin
      done_cnt <= done_cnt + 1'b1;
    end else if (rd_take && !b_fire) begin
      done_cnt <= done_cnt - 1'b1;
    end
  end

  assign host_arready = ddrc_arready & output_avail;
  assign ddrc_arvalid = host_arvalid & output_avail;

  assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_awvalid && !ddrc_awready |=>
      ddrc_awvalid && $stable(ddrc_awaddr) && $stable(ddrc_awlen))
    else $error("writeback_ctrl: ddrc_awvalid dropped before transfer");

endmodule

`default_nettype wire

// ==== dma_block_pipe.sv ====
// top level of the block DMA path: host, memory A, accelerator and
// memory C ports around the input and output sides

`timescale 1ns/10ps
`default_nettype none

module dma_block_pipe
  import dma_block_pkg::*;
(
  input  wire               aclk,
  input  wire               aresetn,

  // host write
  input  wire  [ADDR_W-1:0] host_awaddr,
  input  wire  [LEN_W-1:0]  host_awlen,
  input  wire               host_awvalid,
  output logic              host_awready,
  input  wire  [DATA_W-1:0] host_wdata,
  input  wire               host_wlast,
  input  wire               host_wvalid,
  output logic              host_wready,
  output logic              host_bvalid,
  input  wire               host_bready,
  // host read
  input  wire  [ADDR_W-1:0] host_araddr,
  input  wire  [LEN_W-1:0]  host_arlen,
  input  wire               host_arvalid,
  output logic              host_arready,
  output logic [DATA_W-1:0] host_rdata,
  output logic              host_rlast,
  output logic              host_rvalid,
  input  wire               host_rready,

  // memory A
  output logic [ADDR_W-1:0] ddra_awaddr,
  output logic [LEN_W-1:0]  ddra_awlen,
  output logic              ddra_awvalid,
  input  wire               ddra_awready,
  output logic [DATA_W-1:0] ddra_wdata,
  output logic              ddra_wlast,
  output logic              ddra_wvalid,
  input  wire               ddra_wready,
  input  wire               ddra_bvalid,
  output logic              ddra_bready,
  output logic [ADDR_W-1:0] ddra_araddr,
  output logic [LEN_W-1:0]  ddra_arlen,
  output logic              ddra_arvalid,
  input  wire               ddra_arready,
  input  wire  [DATA_W-1:0] ddra_rdata,
  input  wire               ddra_rvalid,
  output logic              ddra_rready,

  // memory C
  output logic [ADDR_W-1:0] ddrc_awaddr,
  output logic [LEN_W-1:0]  ddrc_awlen,
  output logic              ddrc_awvalid,
  input  wire               ddrc_awready,
  output logic [DATA_W-1:0] ddrc_wdata,
  output logic              ddrc_wlast,
  output logic              ddrc_wvalid,
  input  wire               ddrc_wready,
  input  wire               ddrc_bvalid,
  output logic              ddrc_bready,
  output logic [ADDR_W-1:0] ddrc_araddr,
  output logic [LEN_W-1:0]  ddrc_arlen,
  output logic              ddrc_arvalid,
  input  wire               ddrc_arready,
  input  wire  [DATA_W-1:0] ddrc_rdata,
  input  wire               ddrc_rlast,
  input  wire               ddrc_rvalid,
  output logic              ddrc_rready,

  // accelerator
  output logic [DATA_W-1:0] fifo_in_bits,
  output logic              fifo_in_vld,
  input  wire               fifo_in_rdy,
  input  wire  [DATA_W-1:0] fifo_out_bits,
  input  wire               fifo_out_vld,
  output logic              fifo_out_rdy
);

  logic              issue_fire;
  logic [ADDR_W-1:0] issue_addr;
  logic [LEN_W-1:0]  issue_len;

  // --------------------------------------------------
  // host writes go straight to memory A
  // --------------------------------------------------
  assign ddra_awaddr  = host_awaddr;
  assign ddra_awlen   = host_awlen;
  assign ddra_awvalid = host_awvalid;
  assign host_awready = ddra_awready;
  assign ddra_wdata   = host_wdata;
  assign ddra_wlast   = host_wlast;
  assign ddra_wvalid  = host_wvalid;
  assign host_wready  = ddra_wready;
  assign host_bvalid  = ddra_bvalid;
  assign ddra_bready  = host_bready;

  // memory A read data feeds the accelerator
  assign fifo_in_bits = ddra_rdata;
  assign fifo_in_vld  = ddra_rvalid;
  assign ddra_rready  = fifo_in_rdy;

  // host reads come back from memory C, the gate sits on ar only
  assign ddrc_araddr = host_araddr;
  assign ddrc_arlen  = host_arlen;
  assign host_rdata  = ddrc_rdata;
  assign host_rlast  = ddrc_rlast;
  assign host_rvalid = ddrc_rvalid;
  assign ddrc_rready = host_rready;

  ingest_tracker u_ingest (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .host_awaddr  (host_awaddr),
    .host_awlen   (host_awlen),
    .host_awvalid (host_awvalid),
    .host_awready (ddra_awready),
    .host_bvalid  (ddra_bvalid),
    .host_bready  (host_bready),
    .ddra_arready (ddra_arready),
    .ddra_arvalid (ddra_arvalid),
    .ddra_araddr  (ddra_araddr),
    .ddra_arlen   (ddra_arlen),
    .issue_fire   (issue_fire),
    .issue_addr   (issue_addr),
    .issue_len    (issue_len)
  );

  writeback_ctrl u_writeback (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .issue_fire    (issue_fire),
    .issue_addr    (issue_addr),
    .issue_len     (issue_len),
    .ddrc_awready  (ddrc_awready),
    .ddrc_awvalid  (ddrc_awvalid),
    .ddrc_awaddr   (ddrc_awaddr),
    .ddrc_awlen    (ddrc_awlen),
    .fifo_out_bits (fifo_out_bits),
    .fifo_out_vld  (fifo_out_vld),
    .ddrc_wready   (ddrc_wready),
    .ddrc_wdata    (ddrc_wdata),
    .ddrc_wvalid   (ddrc_wvalid),
    .ddrc_wlast    (ddrc_wlast),
    .ddrc_bready   (ddrc_bready),
    .fifo_out_rdy  (fifo_out_rdy),
    .ddrc_bvalid   (ddrc_bvalid),
    .host_arvalid  (host_arvalid),
    .ddrc_arready  (ddrc_arready),
    .host_arready  (host_arready),
    .ddrc_arvalid  (ddrc_arvalid)
  );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// AXI memory model for the testbench: sparse line store behind
// write and read channels, with random ready stalls

`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
  import dma_block_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h3e6
)
(
  input  wire               aclk,
  input  wire               aresetn,
  input  wire  [ADDR_W-1:0] awaddr,
  input  wire  [LEN_W-1:0]  awlen,
  input  wire               awvalid,
  output logic              awready,
  input  wire  [DATA_W-1:0] wdata,
  input  wire               wvalid,
  output logic              wready,
  output logic              bvalid,
  input  wire               bready,
  input  wire  [ADDR_W-1:0] araddr,
  input  wire  [LEN_W-1:0]  arlen,
  input  wire               arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output logic              rlast,
  output logic              rvalid,
  input  wire               rready
);

  logic [DATA_W-1:0] lines [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] aw_addr_q [$];
  logic [LEN_W-1:0]  aw_len_q [$];
  logic [ADDR_W-1:0] ar_addr_q [$];
  logic [LEN_W-1:0]  ar_len_q [$];
  logic [LEN_W-1:0]  w_beat;
  logic [LEN_W-1:0]  r_beat;
  logic [ADDR_W-1:0] r_line_addr;
  int unsigned       b_pend;
  logic [31:0]       rng;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      aw_addr_q.delete();
      aw_len_q.delete();
      ar_addr_q.delete();
      ar_len_q.delete();
      w_beat = '0;
      r_beat = '0;
      b_pend = 0;
      rng = SEED;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rdata   <= '0;
    end else begin
      // --------------------------------------------------
      // write side, one burst per queued address
      // --------------------------------------------------
      if (awvalid && awready) begin
        aw_addr_q.push_back(awaddr);
        aw_len_q.push_back(awlen);
      end
      if (wvalid && wready) begin
        lines[aw_addr_q[0] + ADDR_W'({w_beat, 6'd0})] = wdata;
        if (w_beat == aw_len_q[0]) begin
          void'(aw_addr_q.pop_front());
          void'(aw_len_q.pop_front());
          w_beat = '0;
          b_pend = b_pend + 1;
        end else begin
          w_beat = w_beat + 1'b1;
        end
      end
      if (bvalid && bready) begin
        b_pend = b_pend - 1;
      end

      // --------------------------------------------------
      // read side
      // --------------------------------------------------
      if (arvalid && arready) begin
        ar_addr_q.push_back(araddr);
        ar_len_q.push_back(arlen);
      end
      if (rvalid && rready) begin
        if (r_beat == ar_len_q[0]) begin
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          r_beat = '0;
        end else begin
          r_beat = r_beat + 1'b1;
        end
      end

      // ready lines stall about one cycle in four
      rng = xorshift32(rng);
      awready <= (rng[1:0] != 2'b00);
      wready  <= (aw_addr_q.size() != 0) && (rng[3:2] != 2'b00);
      arready <= (rng[5:4] != 2'b00);
      bvalid  <= (b_pend != 0);

      if (ar_addr_q.size() != 0) begin
        r_line_addr = ar_addr_q[0] + ADDR_W'({r_beat, 6'd0});
        rvalid <= 1'b1;
        rdata  <= lines.exists(r_line_addr) ? lines[r_line_addr] : '0;
        rlast  <= (r_beat == ar_len_q[0]);
      end else begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_dma_block_pipe.sv ====
// testbench for the block DMA path: host driver, memory and
// accelerator models, scoreboard, protocol checks and watchdog

`timescale 1ns/10ps
`default_nettype none

module tb_dma_block_pipe
  import dma_block_pkg::*;
();

  localparam logic [DATA_W-1:0] ACCEL_MASK = {16{32'h5ac3_0f96}};
  localparam int     NUM_BLOCKS  = 9;
  localparam longint WATCHDOG_NS = longint'(16 + NUM_BLOCKS * BLOCK_BEATS * 40) * 10;

  logic aclk;
  logic aresetn;

  logic [ADDR_W-1:0] host_awaddr, host_araddr;
  logic [LEN_W-1:0]  host_awlen, host_arlen;
  logic [DATA_W-1:0] host_wdata, host_rdata;
  logic host_awvalid, host_awready, host_wlast, host_wvalid, host_wready;
  logic host_bvalid, host_bready, host_arvalid, host_arready;
  logic host_rlast, host_rvalid, host_rready;

  logic [ADDR_W-1:0] ddra_awaddr, ddra_araddr;
  logic [LEN_W-1:0]  ddra_awlen, ddra_arlen;
  logic [DATA_W-1:0] ddra_wdata, ddra_rdata;
  logic ddra_awvalid, ddra_awready, ddra_wlast, ddra_wvalid, ddra_wready;
  logic ddra_bvalid, ddra_bready, ddra_arvalid, ddra_arready, ddra_rvalid, ddra_rready;

  logic [ADDR_W-1:0] ddrc_awaddr, ddrc_araddr;
  logic [LEN_W-1:0]  ddrc_awlen, ddrc_arlen;
  logic [DATA_W-1:0] ddrc_wdata, ddrc_rdata;
  logic ddrc_awvalid, ddrc_awready, ddrc_wlast, ddrc_wvalid, ddrc_wready;
  logic ddrc_bvalid, ddrc_bready, ddrc_arvalid, ddrc_arready;
  logic ddrc_rlast, ddrc_rvalid, ddrc_rready;

  logic [DATA_W-1:0] fifo_in_bits, fifo_out_bits;
  logic fifo_in_vld, fifo_in_rdy, fifo_out_vld, fifo_out_rdy;

  // scoreboard
  logic [DATA_W-1:0] wr_line [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] aw_addr_log [64];
  logic [LEN_W-1:0]  aw_len_log [64];
  logic [ADDR_W-1:0] ar_addr_log [64];
  logic [15:0] aw_cnt, host_b_cnt, ar_cnt, awc_cnt, wbeat_cnt, ddrc_b_cnt, host_ar_cnt;
  logic [15:0] ddra_wbeat_cnt;
  logic [ADDR_W-1:0] exp_araddr, exp_awaddr;
  logic [LEN_W-1:0]  exp_arlen;
  logic [DATA_W-1:0] exp_rdata;
  logic              exp_rlast;
  logic              exp_wlast;
  logic              exp_ddra_wlast;
  logic [31:0]       rng_state;
  int errors;
  int tests_passed;
  int tests_failed;
  int test_start;

  dma_block_pipe uut (.*);

  tb_mem_model #(.SEED(32'h3e6)) mem_a (
    .aclk (aclk), .aresetn (aresetn),
    .awaddr (ddra_awaddr), .awlen (ddra_awlen), .awvalid (ddra_awvalid),
    .awready (ddra_awready), .wdata (ddra_wdata), .wvalid (ddra_wvalid),
    .wready (ddra_wready), .bvalid (ddra_bvalid), .bready (ddra_bready),
    .araddr (ddra_araddr), .arlen (ddra_arlen), .arvalid (ddra_arvalid),
    .arready (ddra_arready), .rdata (ddra_rdata), .rlast (),
    .rvalid (ddra_rvalid), .rready (ddra_rready)
  );

  tb_mem_model #(.SEED(32'h3e6)) mem_c (
    .aclk (aclk), .aresetn (aresetn),
    .awaddr (ddrc_awaddr), .awlen (ddrc_awlen), .awvalid (ddrc_awvalid),
    .awready (ddrc_awready), .wdata (ddrc_wdata), .wvalid (ddrc_wvalid),
    .wready (ddrc_wready), .bvalid (ddrc_bvalid), .bready (ddrc_bready),
    .araddr (ddrc_araddr), .arlen (ddrc_arlen), .arvalid (ddrc_arvalid),
    .arready (ddrc_arready), .rdata (ddrc_rdata), .rlast (ddrc_rlast),
    .rvalid (ddrc_rvalid), .rready (ddrc_rready)
  );

  // accelerator stands in as a pure XOR stage
  assign fifo_out_bits = fifo_in_bits ^ ACCEL_MASK;
  assign fifo_out_vld  = fifo_in_vld;
  assign fifo_in_rdy   = fifo_out_rdy;

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  // --------------------------------------------------
  // handshake counters and address logs
  // --------------------------------------------------
  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      aw_cnt         <= '0;
      host_b_cnt     <= '0;
      ar_cnt         <= '0;
      awc_cnt        <= '0;
      wbeat_cnt      <= '0;
      ddrc_b_cnt     <= '0;
      host_ar_cnt    <= '0;
      ddra_wbeat_cnt <= '0;
    end else begin
      if (host_awvalid && host_awready) begin
        aw_addr_log[aw_cnt[5:0]] <= host_awaddr;
        aw_len_log[aw_cnt[5:0]]  <= host_awlen;
        aw_cnt <= aw_cnt + 16'd1;
      end
      if (host_bvalid && host_bready) host_b_cnt <= host_b_cnt + 16'd1;
      if (ddra_wvalid && ddra_wready) ddra_wbeat_cnt <= ddra_wbeat_cnt + 16'd1;
      if (ddra_arvalid && ddra_arready) begin
        ar_addr_log[ar_cnt[5:0]] <= ddra_araddr;
        ar_cnt <= ar_cnt + 16'd1;
      end
      if (ddrc_awvalid && ddrc_awready) awc_cnt <= awc_cnt + 16'd1;
      if (ddrc_wvalid && ddrc_wready) wbeat_cnt <= wbeat_cnt + 16'd1;
      if (ddrc_bvalid && ddrc_bready) ddrc_b_cnt <= ddrc_b_cnt + 16'd1;
      if (host_arvalid && host_arready) host_ar_cnt <= host_ar_cnt + 16'd1;
    end
  end

  assign exp_araddr     = aw_addr_log[ar_cnt[5:0]];
  assign exp_arlen      = aw_len_log[ar_cnt[5:0]];
  assign exp_awaddr     = ar_addr_log[awc_cnt[5:0]];
  assign exp_wlast      = (wbeat_cnt[5:0] == BEAT_CNT_W'(BLOCK_BEATS - 1));
  assign exp_ddra_wlast = (ddra_wbeat_cnt[5:0] == BEAT_CNT_W'(BLOCK_BEATS - 1));

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  assert property (@(posedge aclk) disable iff (!aresetn) ddra_arvalid |-> host_b_cnt > ar_cnt)
    else begin
      $display("ddra_arvalid went high with no written block left to read");
      errors++;
    end

  assert property (@(posedge aclk) disable iff (!aresetn)
    ddra_arvalid && ddra_arready |-> ddra_araddr == exp_araddr && ddra_arlen == exp_arlen)
    else begin
      $display("CHECK FAILED ddra_araddr/ddra_arlen got %h/%h expected %h/%h",
               $sampled(ddra_araddr), $sampled(ddra_arlen),
               $sampled(exp_araddr), $sampled(exp_arlen));
      errors++;
    end

  assert property (@(posedge aclk) disable iff (!aresetn)
    ddra_wvalid && ddra_wready |-> ddra_wlast == exp_ddra_wlast)
    else begin
      $display("CHECK FAILED ddra_wlast got %h expected %h",
               $sampled(ddra_wlast), $sampled(exp_ddra_wlast));
      errors++;
    end

  assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_awvalid && ddrc_awready |->
      ddrc_awaddr == exp_awaddr && ddrc_awlen == LEN_W'(BLOCK_BEATS - 1))
    else begin
      $display("CHECK FAILED ddrc_awaddr/ddrc_awlen got %h/%h expected %h/%h",
               $sampled(ddrc_awaddr), $sampled(ddrc_awlen),
               $sampled(exp_awaddr), LEN_W'(BLOCK_BEATS - 1));
      errors++;
    end

  assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_wvalid && ddrc_wready |-> ddrc_wlast == exp_wlast)
    else begin
      $display("CHECK FAILED ddrc_wlast got %h expected %h",
               $sampled(ddrc_wlast), $sampled(exp_wlast));
      errors++;
    end

  assert property (@(posedge aclk) disable iff (!aresetn) host_arready |-> ddrc_b_cnt > host_ar_cnt)
    else begin
      $display("host_arready went high while no finished block was waiting");
      errors++;
    end

  assert property (@(posedge aclk) disable iff (!aresetn)
    host_rvalid && host_rready |-> host_rdata == exp_rdata && host_rlast == exp_rlast)
    else begin
      $display("CHECK FAILED host_rdata/host_rlast got %h/%h expected %h/%h",
               $sampled(host_rdata), $sampled(host_rlast),
               $sampled(exp_rdata), $sampled(exp_rlast));
      errors++;
    end

  // --------------------------------------------------
  // host driver
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic make_line(output logic [DATA_W-1:0] line);
    for (int i = 0; i < DATA_W / 32; i++) begin
      rng_state = xorshift32(rng_state);
      line[i*32 +: 32] = rng_state;
    end
  endtask

  task automatic post_write_addr(input logic [ADDR_W-1:0] addr);
    host_awaddr  = addr;
    host_awlen   = LEN_W'(BLOCK_BEATS - 1);
    host_awvalid = 1'b1;
    do @(posedge aclk); while (!host_awready);
    #1 host_awvalid = 1'b0;
  endtask

  task automatic stream_block_data(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] line;
    for (int b = 0; b < BLOCK_BEATS; b++) begin
      make_line(line);
      wr_line[addr + ADDR_W'(b * 64)] = line;
      host_wdata  = line;
      host_wlast  = (b == BLOCK_BEATS - 1);
      host_wvalid = 1'b1;
      do @(posedge aclk); while (!host_wready);
      #1;
    end
    host_wvalid = 1'b0;
    host_wlast  = 1'b0;
    do @(posedge aclk); while (!host_bvalid);
    #1;
  endtask

  task automatic write_block(input logic [ADDR_W-1:0] addr);
    post_write_addr(addr);
    stream_block_data(addr);
  endtask

  task automatic read_block(input logic [ADDR_W-1:0] addr);
    host_araddr  = addr;
    host_arlen   = LEN_W'(BLOCK_BEATS - 1);
    host_arvalid = 1'b1;
    do @(posedge aclk); while (!host_arready);
    #1 host_arvalid = 1'b0;
    for (int b = 0; b < BLOCK_BEATS; b++) begin
      exp_rdata = wr_line[addr + ADDR_W'(b * 64)] ^ ACCEL_MASK;
      exp_rlast = (b == BLOCK_BEATS - 1);
      do @(posedge aclk); while (!host_rvalid);
      #1;
    end
  endtask

  // waits until memory C has answered for a block not yet read back
  task automatic wait_finished();
    do @(posedge aclk); while (ddrc_b_cnt == host_ar_cnt);
    #1;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d check failures", name, errors - errors_before);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with a handshake still pending", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    aresetn      = 1'b0;
    host_awaddr  = '0;
    host_awlen   = '0;
    host_awvalid = 1'b0;
    host_wdata   = '0;
    host_wlast   = 1'b0;
    host_wvalid  = 1'b0;
    host_bready  = 1'b1;
    host_araddr  = '0;
    host_arlen   = '0;
    host_arvalid = 1'b0;
    host_rready  = 1'b1;
    exp_rdata    = '0;
    exp_rlast    = 1'b0;
    rng_state    = 32'h3e6;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) @(posedge aclk);
    #1 aresetn = 1'b1;
    repeat (2) @(posedge aclk);
    #1;

    test_start = errors;
    write_block(64'h0000_0001_0000_0000);
    wait_finished();
    read_block(64'h0000_0001_0000_0000);
    report_test("data round trip", test_start);

    // read goes out before the block has been processed
    test_start = errors;
    write_block(64'h0000_0001_0000_3000);
    read_block(64'h0000_0001_0000_3000);
    report_test("read gating", test_start);

    test_start = errors;
    write_block(64'h0000_0001_0000_8000);
    write_block(64'h0000_0001_0000_2000);
    read_block(64'h0000_0001_0000_8000);
    read_block(64'h0000_0001_0000_2000);
    report_test("memory A read order", test_start);

    test_start = errors;
    write_block(64'h0000_0002_ffff_f000);
    read_block(64'h0000_0002_ffff_f000);
    assert (awc_cnt == ar_cnt && wbeat_cnt == ar_cnt * 16'd64)
      else begin
        $display("CHECK FAILED ddrc aw/w counts got %h/%h expected %h/%h",
                 awc_cnt, wbeat_cnt, ar_cnt, ar_cnt * 16'd64);
        errors++;
      end
    report_test("memory C writes", test_start);

    // all four addresses are queued before any data goes out
    test_start = errors;
    for (int i = 0; i < 4; i++) begin
      post_write_addr(64'h0000_0003_0000_0000 + ADDR_W'(i * 4096));
    end
    for (int i = 0; i < 4; i++) begin
      stream_block_data(64'h0000_0003_0000_0000 + ADDR_W'(i * 4096));
    end
    for (int i = 0; i < 4; i++) begin
      read_block(64'h0000_0003_0000_0000 + ADDR_W'(i * 4096));
    end
    report_test("back-pressure and pipelining", test_start);

    repeat (4) @(posedge aclk);
    $display("tests passed %0d, tests failed %0d, check failures %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
dma_block_pkg.sv
block_addr_fifo.sv
ingest_tracker.sv
writeback_ctrl.sv
dma_block_pipe.sv
tb_mem_model.sv
tb_dma_block_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 --timescale 1ns/10ps \
  --top-module tb_dma_block_pipe -f verilog.f -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
